/* common/arith_consts.svh */
// Datapath, nibble, remainder and opcode width macros
`ifndef ARITH_CONSTS_SVH
`define ARITH_CONSTS_SVH

// Accumulator and operand width
`define ARITH_W 16

// CLA group width, also the multiplier operand width
`define NIB_W 4

// Widest remainder, a divide by 8
`define REM_W 3

`define OP_W 3

`endif

/* common/arithPkg.sv */
// Opcode enum, operand union and the decode and result stage structs
`include "arith_consts.svh"

package arithPkg;

  // Codes 5 to 7 are no-ops
  typedef enum logic [`OP_W-1:0] {
    OP_LOAD = 3'd0,
    OP_ADD  = 3'd1,
    OP_ADC  = 3'd2,
    OP_MUL  = 3'd3,
    OP_DIV  = 3'd4
  } opE;

  typedef struct packed {
    logic [`ARITH_W-3:0] unused;
    logic [1:0]          amount;  // 0 keeps acc, 1..3 divide by 2, 4, 8
  } shiftS;

  // DIV reads the shift view, every other op reads the full word
  typedef union packed {
    logic [`ARITH_W-1:0] data;
    shiftS               shift;
  } operandU;

  typedef struct packed {
    logic    valid;
    opE      op;
    operandU operand;
  } decodedS;

  typedef struct packed {
    logic [`ARITH_W-1:0] acc;
    logic                carry;
    logic [`REM_W-1:0]   rem;
    logic                carryWe;
    logic                remWe;
  } resultS;

endpackage

/* source/opDecode.sv */
// Input register stage that captures an operation into a decoded-operation struct
`timescale 1ns/1ps
`include "arith_consts.svh"

module opDecode (
  input  logic              C,
  input  logic              CLR,
  input  logic              opValid,
  input  arithPkg::opE      op,
  input  arithPkg::operandU operand,
  output arithPkg::decodedS dec
);
  import arithPkg::*;

  logic    validQ;
  opE      opQ;
  operandU operandQ;

  always_ff @(posedge C or posedge CLR)
  begin
    if (CLR)
      validQ <= 1'b0;
    else
      validQ <= opValid;
  end

  // Payload only moves on a strobe, codes 5..7 pass through untouched
  always_ff @(posedge C)
  begin
    if (opValid)
    begin
      opQ      <= op;
      operandQ <= operand;
    end
  end

  assign dec = '{valid: validQ, op: opQ, operand: operandQ};

  // ##################################################
  validKnown: assert property (@(posedge C) disable iff (CLR) !$isunknown(dec.valid))
    else $error("decoded valid is unknown");

endmodule

/* execute/claAdder16.sv */
// 16-bit adder with 4-bit lookahead groups and a second-level group carry lookahead
`timescale 1ns/1ps
`include "arith_consts.svh"

module claAdder16 (
  input  logic [`ARITH_W-1:0] a,
  input  logic [`ARITH_W-1:0] b,
  input  logic                cin,
  output logic [`ARITH_W-1:0] sum,
  output logic                cout
);

  localparam int GROUPS = `ARITH_W / `NIB_W;

  logic [`ARITH_W-1:0] p;
  logic [`ARITH_W-1:0] g;
  logic [GROUPS-1:0]   grpP;
  logic [GROUPS-1:0]   grpG;
  logic [GROUPS:0]     grpC;    // Carry into each group, top one is cout

  // Sum of one nibble with its carries looked ahead from the group carry-in
  function automatic logic [`NIB_W-1:0] nibbleSum(
    input logic [`NIB_W-1:0] pn,
    input logic [`NIB_W-1:0] gn,
    input logic              ci
  );
    logic [`NIB_W-1:0] c;
    c[0] = ci;
    c[1] = gn[0] | (pn[0] & ci);
    c[2] = gn[1] | (pn[1] & gn[0]) | (pn[1] & pn[0] & ci);
    c[3] = gn[2] | (pn[2] & gn[1]) | (pn[2] & pn[1] & gn[0]) | (pn[2] & pn[1] & pn[0] & ci);
    return pn ^ c;
  endfunction

  assign p = a ^ b;
  assign g = a & b;

  for (genvar i = 0; i < GROUPS; i++)
  begin : groupGen
    logic [`NIB_W-1:0] pn;
    logic [`NIB_W-1:0] gn;

    assign pn = p[i*`NIB_W +: `NIB_W];
    assign gn = g[i*`NIB_W +: `NIB_W];

    assign grpP[i] = &pn;
    assign grpG[i] = gn[3] | (pn[3] & gn[2]) | (pn[3] & pn[2] & gn[1])
                   | (pn[3] & pn[2] & pn[1] & gn[0]);

    assign sum[i*`NIB_W +: `NIB_W] = nibbleSum(pn, gn, grpC[i]);
  end

  // ##################################################
  // Second level, every group carry straight from cin
  assign grpC[0] = cin;
  assign grpC[1] = grpG[0] | (grpP[0] & cin);
  assign grpC[2] = grpG[1] | (grpP[1] & grpG[0]) | (grpP[1] & grpP[0] & cin);
  assign grpC[3] = grpG[2] | (grpP[2] & grpG[1]) | (grpP[2] & grpP[1] & grpG[0])
                 | (grpP[2] & grpP[1] & grpP[0] & cin);
  assign grpC[4] = grpG[3] | (grpP[3] & grpG[2]) | (grpP[3] & grpP[2] & grpG[1])
                 | (grpP[3] & grpP[2] & grpP[1] & grpG[0])
                 | (grpP[3] & grpP[2] & grpP[1] & grpP[0] & cin);

  assign cout = grpC[GROUPS];

  always_comb
  begin
    if (!$isunknown({a, b, cin}))
      sumCheck: assert final ({cout, sum} == {1'b0, a} + {1'b0, b} + cin)
        else $error("CLA sum mismatch");
  end

endmodule

/* execute/executeUnit.sv */
// Next accumulator, carry and remainder for one decoded operation
`timescale 1ns/1ps
`include "arith_consts.svh"

module executeUnit (
  input  arithPkg::decodedS   dec,
  input  logic [`ARITH_W-1:0] acc,
  input  logic                carry,
  output arithPkg::resultS    next
);
  import arithPkg::*;

  logic [`ARITH_W-1:0]                   sum;
  logic                                  cout;
  logic                                  cin;
  logic [`NIB_W-1:0][2*`NIB_W-1:0]       pp;   // Partial products for each multiplier bit
  logic [2*`NIB_W-1:0]                   product;
  logic [`ARITH_W-1:0]                   divQ;
  logic [`REM_W-1:0]                     divR;

  assign cin = (dec.op == OP_ADC) ? carry : 1'b0;

  claAdder16 adder0 (
    .a    (acc),
    .b    (dec.operand.data),
    .cin  (cin),
    .sum  (sum),
    .cout (cout)
  );

  // ##################################################
  // 4x4 shift and add multiply on the low nibbles
  always_comb
  begin
    for (int i = 0; i < `NIB_W; i++)
      pp[i] = ({{`NIB_W{1'b0}}, acc[`NIB_W-1:0]} << i) & {(2*`NIB_W){dec.operand.data[i]}};
    product = pp[0] + pp[1] + pp[2] + pp[3];
  end

  // Divide by a power of two and keep the dropped bits as the remainder
  always_comb
  begin
    case (dec.operand.shift.amount)
      2'd1:
      begin
        divQ = {1'b0, acc[`ARITH_W-1:1]};
        divR = {2'b00, acc[0]};
      end
      2'd2:
      begin
        divQ = {2'b00, acc[`ARITH_W-1:2]};
        divR = {1'b0, acc[1:0]};
      end
      2'd3:
      begin
        divQ = {3'b000, acc[`ARITH_W-1:3]};
        divR = acc[2:0];
      end
      default:
      begin
        divQ = acc;
        divR = '0;
      end
    endcase
  end

  always_comb
  begin
    next.acc     = acc;   // No-op codes keep everything
    next.carry   = cout;
    next.rem     = divR;
    next.carryWe = 1'b0;
    next.remWe   = 1'b0;
    case (dec.op)
      OP_LOAD: next.acc = dec.operand.data;
      OP_ADD, OP_ADC:
      begin
        next.acc     = sum;
        next.carryWe = 1'b1;
      end
      OP_MUL: next.acc = {{(`ARITH_W-2*`NIB_W){1'b0}}, product};
      OP_DIV:
      begin
        next.acc   = divQ;
        next.remWe = 1'b1;
      end
      default: ;
    endcase
  end

  // Remainder fits the amount and quotient with remainder rebuild the accumulator
  always_comb
  begin
    if (dec.valid && dec.op == OP_DIV)
      remRange: assert final (int'(next.rem) < (1 << int'(dec.operand.shift.amount))
                              && ((next.acc << dec.operand.shift.amount) | next.rem) == acc)
        else $error("DIV remainder too wide or not the dropped accumulator bits");
  end

endmodule

/* source/resultStage.sv */
// Accumulator, carry and remainder registers with the result valid pulse
`timescale 1ns/1ps
`include "arith_consts.svh"

module resultStage (
  input  logic                C,
  input  logic                CLR,
  input  logic                valid,
  input  arithPkg::resultS    next,
  output logic                resValid,
  output logic                carry,
  output logic [`ARITH_W-1:0] acc,
  output logic [`REM_W-1:0]   rem
);

  always_ff @(posedge C or posedge CLR)
  begin
    if (CLR)
    begin
      resValid <= 1'b0;
      acc      <= '0;
      carry    <= 1'b0;
      rem      <= '0;
    end
    else
    begin
      resValid <= valid;   // One pulse per decoded op
      if (valid)
        acc <= next.acc;
      // Flags only move when the op owns them
      if (valid && next.carryWe)
        carry <= next.carry;
      if (valid && next.remWe)
        rem <= next.rem;
    end
  end

endmodule

/* source/arithUnit.sv */
// Top level of the accumulating arithmetic unit, decode to execute to result
`timescale 1ns/1ps
`include "arith_consts.svh"

module arithUnit (
  input  logic                C,
  input  logic                CLR,
  input  logic                opValid,
  input  arithPkg::opE        op,
  input  arithPkg::operandU   operand,
  output logic                resValid,
  output logic [`ARITH_W-1:0] acc,
  output logic                carry,
  output logic [`REM_W-1:0]   rem
);
  import arithPkg::*;

  decodedS dec;
  resultS  next;

  opDecode decode0 (
    .C       (C),
    .CLR     (CLR),
    .opValid (opValid),
    .op      (op),
    .operand (operand),
    .dec     (dec)
  );

  // Reads back the live accumulator and carry
  executeUnit exec0 (
    .dec   (dec),
    .acc   (acc),
    .carry (carry),
    .next  (next)
  );

  resultStage result0 (
    .C        (C),
    .CLR      (CLR),
    .valid    (dec.valid),
    .next     (next),
    .resValid (resValid),
    .carry    (carry),
    .acc      (acc),
    .rem      (rem)
  );

endmodule

/* tb/arithUnitTb.sv */
// Testbench for arithUnit with file-driven operations, expected-result queue and report
`timescale 1ns/1ps
`include "arith_consts.svh"

module arithUnitTb;
  import arithPkg::*;

  logic                C;
  logic                CLR;
  logic                opValid;
  opE                  op;
  operandU             operand;
  logic                resValid;
  logic [`ARITH_W-1:0] acc;
  logic                carry;
  logic [`REM_W-1:0]   rem;

  // Test table with one entry per line of the data file
  string               names[$];
  logic [`OP_W-1:0]    opCodes[$];
  logic [`ARITH_W-1:0] operands[$];
  logic [`ARITH_W-1:0] expAcc[$];
  logic                expCarry[$];
  logic [`REM_W-1:0]   expRem[$];

  int expQ[$];          // Indices of tests still in flight
  int passed;
  int failed;
  int otherErrors;
  int cycles;
  int limit;
  bit loaded;

  arithUnit dut0 (
    .C        (C),
    .CLR      (CLR),
    .opValid  (opValid),
    .op       (op),
    .operand  (operand),
    .resValid (resValid),
    .acc      (acc),
    .carry    (carry),
    .rem      (rem)
  );

  initial
  begin
    C = 1'b0;
    forever #5 C = ~C;
  end

  // ##################################################
  // Compare tasks for each result kind

  task automatic checkAcc(input logic [`ARITH_W-1:0] expV, input logic [`ARITH_W-1:0] actV,
                          inout string msg);
    if (actV !== expV)
      msg = {msg, $sformatf(" acc expected %h actual %h", expV, actV)};
  endtask

  task automatic checkCarry(input logic expV, input logic actV, inout string msg);
    if (actV !== expV)
      msg = {msg, $sformatf(" carry expected %b actual %b", expV, actV)};
  endtask

  task automatic checkRem(input logic [`REM_W-1:0] expV, input logic [`REM_W-1:0] actV,
                          inout string msg);
    if (actV !== expV)
      msg = {msg, $sformatf(" rem expected %h actual %h", expV, actV)};
  endtask

  // ##################################################

  task automatic loadTests(output bit ok);
    int    fd;
    int    code;
    int    n;
    string line;
    string nameV;
    int    opV;
    int    valV;
    int    accV;
    int    cV;
    int    rV;
    ok = 1'b0;
    fd = $fopen("tb/arith_tests.txt", "r");
    if (fd == 0)
      return;
    while (!$feof(fd))
    begin
      code = $fgets(line, fd);
      if (code == 0)
        continue;
      if (line.len() == 0 || line.getc(0) == "#")
        continue;   // Column header or comment
      n = $sscanf(line, "%s %h %h %h %h %h", nameV, opV, valV, accV, cV, rV);
      if (n == 6)
      begin
        names.push_back(nameV);
        opCodes.push_back(opV[`OP_W-1:0]);
        operands.push_back(valV[`ARITH_W-1:0]);
        expAcc.push_back(accV[`ARITH_W-1:0]);
        expCarry.push_back(cV[0]);
        expRem.push_back(rV[`REM_W-1:0]);
      end
      else if (n > 0)
      begin
        $display("Malformed line in test file: %s", line);
        otherErrors++;
      end
    end
    $fclose(fd);
    ok = 1'b1;
  endtask

  // Checks whatever result is on the outputs at this falling edge
  task automatic collectResult();
    int    t;
    string msg;
    msg = "";
    if (resValid === 1'b1)
    begin
      if (expQ.size() == 0)
      begin
        $display("resValid pulsed while no operation was outstanding");
        otherErrors++;
      end
      else
      begin
        t = expQ.pop_front();
        checkAcc(expAcc[t], acc, msg);
        checkCarry(expCarry[t], carry, msg);
        checkRem(expRem[t], rem, msg);
        if (msg.len() != 0)
        begin
          failed++;
          $display("[FAIL] %s%s", names[t], msg);
        end
        else
        begin
          passed++;
          $display("[PASS] %s", names[t]);
        end
      end
    end
    else if (resValid !== 1'b0)
    begin
      $display("resValid is unknown after reset");
      otherErrors++;
    end
  endtask

  task automatic nextCycle();
    @(negedge C);
    collectResult();
  endtask

  task automatic driveOp(input int t);
    opValid      = 1'b1;
    op           = opE'(opCodes[t]);   // 5..7 are no-op codes outside the enum
    operand.data = operands[t];
    expQ.push_back(t);
  endtask

  // Stops a stuck run
  initial
  begin
    cycles = 0;
    wait (limit > 0);
    while (cycles < limit)
    begin
      @(posedge C);
      cycles++;
    end
    $display("Timeout after %0d cycles, the run did not finish", cycles);
    $display("TEST FAIL");
    $finish;
  end

  initial
  begin
    CLR          = 1'b1;
    opValid      = 1'b0;
    op           = OP_LOAD;
    operand.data = '0;
    passed       = 0;
    failed       = 0;
    otherErrors  = 0;
    limit        = 0;
    void'($urandom(32'hab2));
    loadTests(loaded);
    if (!loaded || names.size() == 0)
    begin
      $display("Could not read any tests from tb/arith_tests.txt");
      $display("TEST FAIL");
      $finish;
    end
    else
    begin
      limit = 4 * names.size() + 50;
      repeat (4) @(negedge C);
      CLR = 1'b0;
      for (int i = 0; i < names.size(); i++)
      begin
        if ($urandom % 2)
        begin
          nextCycle();
          opValid = 1'b0;   // One idle cycle
        end
        nextCycle();
        driveOp(i);
      end
      nextCycle();
      opValid = 1'b0;
      repeat (6) nextCycle();
      if (expQ.size() != 0)
      begin
        $display("%0d expected results never arrived", expQ.size());
        otherErrors++;
      end
      $display("Tests: %0d total, %0d passed, %0d failed, %0d other errors",
               names.size(), passed, failed, otherErrors);
      if (failed == 0 && otherErrors == 0)
        $display("TEST PASS");
      else
        $display("TEST FAIL");
      $finish;
    end
  end

endmodule

/* tb/arith_tests.txt */
# name op operand acc carry rem, all hex after the name
# op 0 LOAD, 1 ADD, 2 ADC, 3 MUL, 4 DIV, 5..7 no-op; values are after the op
load1 0 1234 1234 0 0
add1 1 0ff0 2224 0 0
ldFfff 0 ffff ffff 0 0
addWrap 1 0001 0000 1 0
adcOne 2 0010 0011 0 0
addNoOv 1 0100 0111 0 0
adcZero 2 0002 0113 0 0
ldBig 0 8000 8000 0 0
addOv 1 8001 0001 1 0
ldMul 0 abcf abcf 1 0
mulFF 3 123f 00e1 1 0
mulOne 3 0003 0003 1 0
adcCarry 2 fffc 0000 1 0
adcAgain 2 0005 0006 0 0
ld7 0 0007 0007 0 0
mul76 3 fff6 002a 0 0
mulZero 3 0000 0000 0 0
ldDiv 0 abcd abcd 0 0
div1 4 0001 55e6 0 1
div2 4 0002 1579 0 2
div3 4 0003 02af 0 1
div0 4 0000 02af 0 0
divHiBits 4 fffd 0157 0 1
nop5 5 ffff 0157 0 1
addCross 1 fea9 0000 1 1
nop6 6 1234 0000 1 1
nop7 7 0000 0000 1 1
ldEnd 0 0005 0005 1 1
divEnd 4 0002 0001 1 1
adcEnd 2 0000 0002 0 1

/* flist.f */
+incdir+common
common/arithPkg.sv
source/opDecode.sv
execute/claAdder16.sv
execute/executeUnit.sv
source/resultStage.sv
source/arithUnit.sv
tb/arithUnitTb.sv
